//--- dv/bch_cases.txt
# rate_sel start step stall abort back_to_back parity
# data byte i = start + step * i, parity highest byte first
0 01 01 0 0 0 d90c
1 ff 00 0 0 0 fed3
2 80 00 0 0 0 fac2
3 00 00 0 0 0 0000
0 01 01 1 0 0 d90c
2 80 00 1 0 0 fac2
1 ff 00 0 1 0 fed3
0 01 01 0 0 1 d90c
2 80 00 0 0 0 fac2
1 ff 00 0 0 1 fed3
0 01 01 0 0 0 d90c

//--- bch_encoder_top.f
logic/bch_code_pkg.sv
logic/bch_frame_pkg.sv
logic/bch_frame_ctrl.sv
logic/bch_byte_divider.sv
logic/bch_parity_shifter.sv
logic/bch_encoder_top.sv
dv/bch_encoder_chk.sv
dv/bch_encoder_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= bch_encoder_tb
RTL_TOP   ?= bch_encoder_top
FILELIST  ?= bch_encoder_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/bch_encoder_tb.sv
`timescale 1ns/1ns

module bch_encoder_tb;

	localparam int NBYTES = bch_code_pkg::DEF_PARITY_BITS / 8;

	logic                     sys_clk;
	logic                     rst_n;
	logic                     fs_en;
	logic                     init_vld;
	logic                     frame_vld;
	bch_frame_pkg::rate_sel_t rate_sel;
	bch_code_pkg::byte_t      byte_in;
	logic                     oe;
	bch_code_pkg::byte_t      byte_out;

	int err_cnt;
	int tmo_cnt;
	int frames_seen;
	int cyc;

	// case file columns
	int c_rate[$];
	int c_start[$];
	int c_step[$];
	int c_stall[$];
	int c_abort[$];
	int c_b2b[$];
	int c_par[$];

	// expected results in frame order
	logic [15:0] exp_par[$];
	int          exp_rise[$];

	// burst collection
	int          nb;
	int          first_cyc;
	logic [15:0] got_par;
	bit          low_due;

	bch_encoder_top i_dut (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.fs_en     (fs_en),
		.init_vld  (init_vld),
		.frame_vld (frame_vld),
		.rate_sel  (rate_sel),
		.byte_in   (byte_in),
		.oe        (oe),
		.byte_out  (byte_out)
	);

	initial begin
		sys_clk = 1'b0;
		forever begin
			#5 sys_clk = ~sys_clk;
		end
	end

	always @(posedge sys_clk) begin
		cyc <= cyc + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// output collection at mid cycle
	////////////////////////////////////////////////////////////////////////////

	always @(negedge sys_clk) begin
		if (rst_n && fs_en) begin
			if (oe) begin
				if (low_due) begin
					$display("ERR @%0t: oe still high after %0d parity bytes", $time,
						NBYTES);
					err_cnt++;
				end
				low_due = 1'b0;
				if (nb == 0) begin
					first_cyc = cyc;
				end
				got_par = {got_par[7:0], byte_out};
				nb++;
				if (nb == NBYTES) begin
					frames_seen++;
					if (exp_par.size() == 0) begin
						$display("ERR @%0t: parity %h with no frame pending", $time, got_par);
						err_cnt++;
					end else begin
						if (got_par !== exp_par[0]) begin
							$display("ERR @%0t: parity %h, expected %h", $time, got_par,
								exp_par[0]);
							err_cnt++;
						end
						if (exp_rise[0] >= 0 && first_cyc != exp_rise[0]) begin
							$display("ERR @%0t: oe rose at cycle %0d, expected %0d", $time,
								first_cyc, exp_rise[0]);
							err_cnt++;
						end
						void'(exp_par.pop_front());
						void'(exp_rise.pop_front());
					end
					nb      = 0;
					low_due = 1'b1;
				end
			end else begin
				low_due = 1'b0;
				if (nb != 0) begin
					$display("ERR @%0t: oe fell after %0d parity bytes", $time, nb);
					err_cnt++;
				end
				nb = 0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic int frame_len(input int rate);
		case (rate)
			0: return 6;
			1: return 11;
			2: return 17;
			default: return 24;
		endcase
	endfunction

	task automatic read_cases();
		int    fd;
		int    n;
		int    r, s, t, st, ab, bb, p;
		string line;

		fd = $fopen("dv/bch_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file dv/bch_cases.txt");
			err_cnt++;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n == 0 || line.len() < 3 || line.getc(0) == "#") begin
					continue;
				end
				n = $sscanf(line, "%d %h %h %d %d %d %h", r, s, t, st, ab, bb, p);
				if (n != 7) begin
					$display("malformed line in the case file: %s", line);
					err_cnt++;
					continue;
				end
				c_rate.push_back(r);
				c_start.push_back(s);
				c_step.push_back(t);
				c_stall.push_back(st);
				c_abort.push_back(ab);
				c_b2b.push_back(bb);
				c_par.push_back(p);
			end
			$fclose(fd);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge sys_clk);
			#1;
			fs_en     = 1'b1;
			frame_vld = 1'b0;
			init_vld  = 1'b0;
		end
	endtask

	// each byte is held until an enabled edge takes it
	task automatic send_bytes(input int rate, input int start, input int step,
		input bit stall, input int count);
		int         i;
		int         tries;
		logic [7:0] d;

		for (i = 0; i < count; i++) begin
			d     = 8'(start + step * i);
			tries = 0;
			do begin
				@(posedge sys_clk);
				#1;
				fs_en = stall ? (($urandom % 4) != 0) : 1'b1;
				if (tries >= 40) begin
					fs_en = 1'b1;
				end
				frame_vld = 1'b1;
				byte_in   = d;
				// later bytes carry another mode that must not count
				rate_sel  = (i == 0) ? bch_frame_pkg::rate_sel_t'(rate) :
					bch_frame_pkg::rate_sel_t'(rate ^ 3);
				tries++;
			end while (!fs_en);
		end
	endtask

	task automatic abort_frame();
		@(posedge sys_clk);
		#1;
		fs_en     = 1'b1;
		frame_vld = 1'b0;
		init_vld  = 1'b1;
		@(posedge sys_clk);
		#1;
		init_vld = 1'b0;
	endtask

	task automatic drain_parity(input bit stall, input int limit);
		int cnt;

		cnt = 0;
		while (exp_par.size() != 0 && cnt < limit) begin
			@(posedge sys_clk);
			#1;
			fs_en     = stall ? (($urandom % 4) != 0) : 1'b1;
			frame_vld = 1'b0;
			cnt++;
		end
		if (exp_par.size() != 0) begin
			$display("timeout: parity burst did not finish within %0d cycles", limit);
			tmo_cnt++;
		end
		fs_en = 1'b1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int c;
		int len;

		rst_n       = 1'b0;
		fs_en       = 1'b0;
		init_vld    = 1'b0;
		frame_vld   = 1'b0;
		rate_sel    = '0;
		byte_in     = '0;
		err_cnt     = 0;
		tmo_cnt     = 0;
		frames_seen = 0;
		cyc         = 0;
		nb          = 0;
		first_cyc   = 0;
		got_par     = '0;
		low_due     = 1'b0;
		void'($urandom(79));

		read_cases();

		repeat (8) @(posedge sys_clk);
		#1;
		rst_n = 1'b1;
		idle_cycles(2);
		if (oe !== 1'b0) begin
			$display("ERR @%0t: oe high after reset", $time);
			err_cnt++;
		end

		for (c = 0; c < c_rate.size(); c++) begin
			len = frame_len(c_rate[c]);
			if (c_abort[c] != 0) begin
				send_bytes(c_rate[c], c_start[c], c_step[c], 1'b0, len / 2);
				abort_frame();
				idle_cycles(2);
			end
			send_bytes(c_rate[c], c_start[c], c_step[c], c_stall[c] != 0, len);
			exp_par.push_back(16'(c_par[c]));
			exp_rise.push_back((c_stall[c] != 0) ? -1 : cyc + 2);
			if (c_stall[c] != 0) begin
				drain_parity(1'b1, 400);
			end else if (c_b2b[c] == 0) begin
				idle_cycles(3);
			end
		end

		drain_parity(1'b0, 200);
		idle_cycles(10);

		if (frames_seen != c_rate.size() || frames_seen == 0) begin
			$display("ERR @%0t: %0d parity bursts for %0d frames", $time, frames_seen,
				c_rate.size());
			err_cnt++;
		end

		$display("checked %0d frames: %0d errors, %0d timeouts", frames_seen, err_cnt,
			tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- dv/bch_encoder_chk.sv
`timescale 1ns/1ns

module bch_encoder_chk #(
	parameter int PARITY_BITS = 16
) (
	input logic       sys_clk,
	input logic       rst_n,
	input logic       fs_en,
	input logic       oe,
	input logic [7:0] byte_out
);

	localparam int NBYTES = PARITY_BITS / 8;

	// enabled edges in a row with oe high
	int oe_run;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			oe_run <= 0;
		end else if (fs_en) begin
			oe_run <= oe ? oe_run + 1 : 0;
		end
	end

	a_oe_reset : assert property (@(posedge sys_clk) !rst_n |=> !oe)
		else $error("oe high during or right after reset");

	a_oe_len : assert property (@(posedge sys_clk) disable iff (!rst_n) oe_run <= NBYTES)
		else $error("oe high for more than %0d enabled edges", NBYTES);

	a_hold : assert property (@(posedge sys_clk) disable iff (!rst_n)
		!fs_en |=> $stable(byte_out))
		else $error("byte_out changed without fs_en");

endmodule

bind bch_encoder_top bch_encoder_chk #(
	.PARITY_BITS (PARITY_BITS)
) i_chk (
	.sys_clk  (sys_clk),
	.rst_n    (rst_n),
	.fs_en    (fs_en),
	.oe       (oe),
	.byte_out (byte_out)
);

//--- logic/bch_encoder_top.sv
`timescale 1ns/1ns

module bch_encoder_top #(
	parameter int                     PARITY_BITS = bch_code_pkg::DEF_PARITY_BITS,
	parameter logic [PARITY_BITS-1:0] GEN_POLY    = bch_code_pkg::DEF_GEN_POLY
) (
	input  logic                     sys_clk,
	input  logic                     rst_n,
	input  logic                     fs_en,
	input  logic                     init_vld,
	input  logic                     frame_vld,
	input  bch_frame_pkg::rate_sel_t rate_sel,
	input  bch_code_pkg::byte_t      byte_in,
	output logic                     oe,
	output bch_code_pkg::byte_t      byte_out
);

	logic                   byte_accept;
	logic                   first_byte;
	logic                   frame_done;
	logic [PARITY_BITS-1:0] remainder;

	////////////////////////////////////////////////////////////////////////////
	// framing, division, parity output
	////////////////////////////////////////////////////////////////////////////

	bch_frame_ctrl i_frame_ctrl (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.fs_en       (fs_en),
		.init_vld    (init_vld),
		.frame_vld   (frame_vld),
		.rate_sel    (rate_sel),
		.byte_accept (byte_accept),
		.first_byte  (first_byte),
		.frame_done  (frame_done)
	);

	bch_byte_divider #(
		.PARITY_BITS (PARITY_BITS),
		.GEN_POLY    (GEN_POLY)
	) i_byte_divider (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.fs_en       (fs_en),
		.init_vld    (init_vld),
		.byte_accept (byte_accept),
		.byte_in     (byte_in),
		.first_byte  (first_byte),
		.remainder   (remainder)
	);

	// remainder is captured here so the next frame may start at once
	bch_parity_shifter #(
		.PARITY_BITS (PARITY_BITS)
	) i_parity_shifter (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.fs_en      (fs_en),
		.init_vld   (init_vld),
		.frame_done (frame_done),
		.remainder  (remainder),
		.oe         (oe),
		.byte_out   (byte_out)
	);

endmodule

//--- logic/bch_parity_shifter.sv
`timescale 1ns/1ns

module bch_parity_shifter #(
	parameter int PARITY_BITS = 16
) (
	input  logic                   sys_clk,
	input  logic                   rst_n,
	input  logic                   fs_en,
	input  logic                   init_vld,
	input  logic                   frame_done,
	input  logic [PARITY_BITS-1:0] remainder,
	output logic                   oe,
	output bch_code_pkg::byte_t    byte_out
);

	localparam int NBYTES = PARITY_BITS / 8;
	localparam int CNT_W  = (NBYTES > 1) ? $clog2(NBYTES) : 1;

	bch_code_pkg::shift_state_e state;
	logic [CNT_W-1:0]           byte_cnt;
	logic [PARITY_BITS-1:0]     shift_q;

	// highest degree byte sits at the top
	assign byte_out = shift_q[PARITY_BITS-1 -: 8];
	assign oe       = (state == bch_code_pkg::SH_SEND);

	////////////////////////////////////////////////////////////////////////////
	// load on frame_done, one byte per enabled edge
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state    <= bch_code_pkg::SH_IDLE;
			byte_cnt <= '0;
			shift_q  <= '0;
		end else if (fs_en) begin
			if (init_vld) begin
				state    <= bch_code_pkg::SH_IDLE;
				byte_cnt <= '0;
				shift_q  <= '0;
			end else if (frame_done) begin
				state    <= bch_code_pkg::SH_SEND;
				byte_cnt <= '0;
				shift_q  <= remainder;
			end else if (state == bch_code_pkg::SH_SEND) begin
				if (byte_cnt == CNT_W'(NBYTES - 1)) begin
					// last byte has been out for one cycle
					state <= bch_code_pkg::SH_IDLE;
				end else begin
					byte_cnt <= byte_cnt + CNT_W'(1);
					shift_q  <= {shift_q[PARITY_BITS-9:0], 8'h00};
				end
			end
		end
	end

endmodule

//--- logic/bch_byte_divider.sv
`timescale 1ns/1ns

module bch_byte_divider #(
	parameter int                   PARITY_BITS = 16,
	parameter logic [PARITY_BITS-1:0] GEN_POLY  = '0
) (
	input  logic                     sys_clk,
	input  logic                     rst_n,
	input  logic                     fs_en,
	input  logic                     init_vld,
	input  logic                     byte_accept,
	input  bch_code_pkg::byte_t      byte_in,
	input  logic                     first_byte,
	output logic [PARITY_BITS-1:0]   remainder
);

	logic [PARITY_BITS-1:0] rem_next;

	////////////////////////////////////////////////////////////////////////////
	// eight division steps, bit 7 first
	////////////////////////////////////////////////////////////////////////////

	always_comb begin : div_steps
		logic [PARITY_BITS-1:0] r;
		logic                   fb;

		// a new frame starts from an empty register
		r = first_byte ? '0 : remainder;
		for (int i = 7; i >= 0; i--) begin
			fb = r[PARITY_BITS-1] ^ byte_in[i];
			r  = {r[PARITY_BITS-2:0], 1'b0};
			if (fb) begin
				r = r ^ GEN_POLY;
			end
		end
		rem_next = r;
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			remainder <= '0;
		end else if (fs_en) begin
			if (init_vld) begin
				remainder <= '0;
			end else if (byte_accept) begin
				remainder <= rem_next;
			end
		end
	end

endmodule

//--- logic/bch_frame_ctrl.sv
`timescale 1ns/1ns

module bch_frame_ctrl (
	input  logic                    sys_clk,
	input  logic                    rst_n,
	input  logic                    fs_en,
	input  logic                    init_vld,
	input  logic                    frame_vld,
	input  bch_frame_pkg::rate_sel_t rate_sel,
	output logic                    byte_accept,
	output logic                    first_byte,
	output logic                    frame_done
);

	bch_frame_pkg::frame_state_e state;
	bch_frame_pkg::info_len_t    byte_cnt;
	bch_frame_pkg::info_len_t    frame_len;
	bch_frame_pkg::info_len_t    cur_len;
	logic                        last_byte;

	////////////////////////////////////////////////////////////////////////////
	// byte strobes
	////////////////////////////////////////////////////////////////////////////

	assign byte_accept = fs_en & frame_vld;
	assign first_byte  = byte_accept && (byte_cnt == '0);

	// table value on the first byte, latched length after that
	assign cur_len = (state == bch_frame_pkg::FR_IDLE) ?
		bch_frame_pkg::INFO_LEN_TABLE[rate_sel] : frame_len;

	assign last_byte = byte_accept &&
		(byte_cnt == cur_len - bch_frame_pkg::info_len_t'(1));

	////////////////////////////////////////////////////////////////////////////
	// count and state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state      <= bch_frame_pkg::FR_IDLE;
			byte_cnt   <= '0;
			frame_len  <= '0;
			frame_done <= 1'b0;
		end else if (fs_en) begin
			if (init_vld) begin
				state      <= bch_frame_pkg::FR_IDLE;
				byte_cnt   <= '0;
				frame_done <= 1'b0;
			end else begin
				frame_done <= last_byte;
				if (first_byte) begin
					frame_len <= cur_len;
				end
				if (byte_accept) begin
					if (last_byte) begin
						// wrap, next byte opens a new frame
						byte_cnt <= '0;
						state    <= bch_frame_pkg::FR_IDLE;
					end else begin
						byte_cnt <= byte_cnt + bch_frame_pkg::info_len_t'(1);
						state    <= bch_frame_pkg::FR_DATA;
					end
				end
			end
		end
	end

endmodule

//--- logic/bch_frame_pkg.sv
package bch_frame_pkg;

	////////////////////////////////////////////////////////////////////////////
	// framing definitions
	////////////////////////////////////////////////////////////////////////////

	// frame mode, picks a row of the length table
	typedef logic [1:0] rate_sel_t;

	// information bytes per frame
	typedef logic [4:0] info_len_t;

	// lengths per rate_sel value, all at least two parity bytes long
	parameter info_len_t INFO_LEN_TABLE [0:3] = '{
		5'd6,
		5'd11,
		5'd17,
		5'd24
	};

	// frame controller
	typedef enum logic {
		FR_IDLE = 1'b0,
		FR_DATA = 1'b1
	} frame_state_e;

endpackage

//--- logic/bch_code_pkg.sv
package bch_code_pkg;

	////////////////////////////////////////////////////////////////////////////
	// code level definitions
	////////////////////////////////////////////////////////////////////////////

	// one information or parity byte
	typedef logic [7:0] byte_t;

	// degree of the default generator polynomial
	parameter int DEF_PARITY_BITS = 16;

	// x^16 + x^12 + x^5 + 1, leading term left out
	parameter logic [DEF_PARITY_BITS-1:0] DEF_GEN_POLY = 16'h1021;

	// parity shifter
	typedef enum logic {
		SH_IDLE = 1'b0,
		SH_SEND = 1'b1
	} shift_state_e;

endpackage
